//--- design/fetch_pkg.sv
package fetch_pkg;

    // Core sizing
    localparam int num_warps   = 4;
    localparam int wid_bits    = 2;
    localparam int num_threads = 4;
    localparam int uuid_bits   = 8;

    // Instruction buffer depth per warp
    localparam int ibuf_size = 2;

    localparam logic [31:0] startup_addr = 32'h8000_0000;

    // Instruction memory geometry
    localparam int mem_words        = 256;
    localparam int mem_addr_bits    = 8;
    localparam int mem_latency      = 2;
    localparam int icache_addr_bits = 30;

    // Fetch request from the warp scheduler
    typedef struct packed {
        logic [wid_bits-1:0]    wid;
        logic [31:0]            pc;
        logic [num_threads-1:0] tmask;
        logic [uuid_bits-1:0]   uuid;
    } ifetch_req_t;

    // Tag carried through the cache
    typedef struct packed {
        logic [uuid_bits-1:0] uuid;
        logic [wid_bits-1:0]  wid;
    } icache_tag_t;

    typedef struct packed {
        logic [icache_addr_bits-1:0] addr;
        icache_tag_t                 tag;
    } icache_req_t;

    typedef struct packed {
        logic [31:0] data;
        icache_tag_t tag;
    } icache_rsp_t;

    // Rebuilt fetch response toward decode
    typedef struct packed {
        logic [wid_bits-1:0]    wid;
        logic [31:0]            pc;
        logic [num_threads-1:0] tmask;
        logic [31:0]            data;
        logic [uuid_bits-1:0]   uuid;
    } ifetch_rsp_t;

    typedef struct packed {
        logic [mem_addr_bits-1:0] addr;
        logic [31:0]              data;
    } mem_fill_t;

endpackage

//--- design/fetch_meta_ram.sv
module fetch_meta_ram (
    input  logic                                clk,
    input  logic                                wren,
    input  logic [fetch_pkg::wid_bits-1:0]      waddr,
    input  logic [fetch_pkg::wid_bits-1:0]      raddr,
    input  logic [31+fetch_pkg::num_threads:0]  wdata,
    output logic [31+fetch_pkg::num_threads:0]  rdata
);

    // One entry per warp, holding {pc, tmask}
    logic [31+fetch_pkg::num_threads:0] mem [fetch_pkg::num_warps];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[waddr] <= wdata;
        end
    end

    // LUT-style read, no output register
    assign rdata = mem[raddr];

endmodule

//--- design/pending_counter.sv
module pending_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic incr,
    input  logic decr,
    output logic full
);

    // Holds 0 up to ibuf_size + 1
    typedef logic [$clog2(fetch_pkg::ibuf_size + 2)-1:0] count_t;

    count_t count;
    count_t count_next;
    count_t count_top;

    assign count_top = count_t'(fetch_pkg::ibuf_size + 1);

    always_comb begin
        count_next = count;
        if (incr && !decr && count != count_top) begin
            count_next = count + 1'b1;
        end else if (decr && !incr && count != '0) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            full  <= 1'b0;
        end else begin
            count <= count_next;
            // Flag tracks the new count
            full  <= (count_next == count_top);
        end
    end

endmodule

//--- design/skid_buffer.sv
module skid_buffer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   valid_in,
    output logic                   ready_in,
    input  fetch_pkg::icache_req_t data_in,
    output logic                   valid_out,
    input  logic                   ready_out,
    output fetch_pkg::icache_req_t data_out
);

    logic                   main_valid;
    logic                   spare_valid;
    logic                   main_load;
    fetch_pkg::icache_req_t main_data;
    fetch_pkg::icache_req_t spare_data;

    // Main register may take a new beat this cycle
    assign main_load = ready_out || !main_valid;

    // Upstream only sees the spare occupancy, one cycle behind
    assign ready_in = !spare_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_load) begin
            if (spare_valid) begin
                main_valid  <= 1'b1;
                spare_valid <= 1'b0;
            end else begin
                main_valid <= valid_in;
            end
        end else if (valid_in && ready_in) begin
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            // Older beat in the spare goes first
            main_data <= spare_valid ? spare_data : data_in;
        end else if (valid_in && ready_in) begin
            spare_data <= data_in;
        end
    end

    assign valid_out = main_valid;
    assign data_out  = main_data;

endmodule

//--- design/icache_stage.sv
module icache_stage (
    input  logic                             clk,
    input  logic                             arst_n,

    // Fetch request from scheduler
    input  logic                             req_valid,
    input  fetch_pkg::ifetch_req_t           req,
    output logic                             req_ready,

    // Instruction cache request
    output logic                             creq_valid,
    output fetch_pkg::icache_req_t           creq,
    input  logic                             creq_ready,

    // Instruction cache response
    input  logic                             crsp_valid,
    input  fetch_pkg::icache_rsp_t           crsp,
    output logic                             crsp_ready,

    // Fetch response toward decode
    output logic                             rsp_valid,
    output fetch_pkg::ifetch_rsp_t           rsp,
    input  logic                             rsp_ready,

    input  logic [fetch_pkg::num_warps-1:0]  ibuf_pop
);

    logic                                sbuf_ready;
    logic                                sbuf_valid;
    logic                                req_fire;
    logic [fetch_pkg::num_warps-1:0]     warp_full;
    logic [fetch_pkg::num_warps-1:0]     warp_fire;
    fetch_pkg::icache_req_t              sbuf_in;
    logic [31+fetch_pkg::num_threads:0]  meta_rdata;

    // Word address and {uuid, wid} tag
    assign sbuf_in.addr     = req.pc[31:2];
    assign sbuf_in.tag.uuid = req.uuid;
    assign sbuf_in.tag.wid  = req.wid;

    // Throttle so the instruction buffer never overflows
    assign sbuf_valid = req_valid && !warp_full[req.wid];
    assign req_ready  = sbuf_ready && !warp_full[req.wid];
    assign req_fire   = req_valid && req_ready;

    always_comb begin
        warp_fire          = '0;
        warp_fire[req.wid] = req_fire;
    end

    for (genvar i = 0; i < fetch_pkg::num_warps; i++) begin : g_pending
        pending_counter u_pending_counter (
            .clk    (clk),
            .arst_n (arst_n),
            .incr   (warp_fire[i]),
            .decr   (ibuf_pop[i]),
            .full   (warp_full[i])
        );
    end

    // PC and tmask kept here rather than carried through the cache
    fetch_meta_ram u_meta_ram (
        .clk   (clk),
        .wren  (req_fire),
        .waddr (req.wid),
        .wdata ({req.pc, req.tmask}),
        .raddr (crsp.tag.wid),
        .rdata (meta_rdata)
    );

    skid_buffer u_req_sbuf (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (sbuf_valid),
        .ready_in  (sbuf_ready),
        .data_in   (sbuf_in),
        .valid_out (creq_valid),
        .ready_out (creq_ready),
        .data_out  (creq)
    );

    // Response rebuilt from tag and metadata
    assign rsp_valid  = crsp_valid;
    assign rsp.wid    = crsp.tag.wid;
    assign rsp.pc     = meta_rdata[31+fetch_pkg::num_threads:fetch_pkg::num_threads];
    assign rsp.tmask  = meta_rdata[fetch_pkg::num_threads-1:0];
    assign rsp.data   = crsp.data;
    assign rsp.uuid   = crsp.tag.uuid;
    assign crsp_ready = rsp_ready;

endmodule

//--- design/instr_mem.sv
module instr_mem (
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   req_valid,
    input  fetch_pkg::icache_req_t req,
    output logic                   req_ready,

    output logic                   rsp_valid,
    output fetch_pkg::icache_rsp_t rsp,
    input  logic                   rsp_ready,

    // Program load port
    input  logic                   fill_valid,
    input  fetch_pkg::mem_fill_t   fill
);

    logic [31:0] mem [fetch_pkg::mem_words];

    logic [fetch_pkg::mem_latency-1:0] stg_valid;
    fetch_pkg::icache_rsp_t            stg_rsp [fetch_pkg::mem_latency];
    logic                              stall;

    // Whole pipeline freezes on a held response
    assign stall     = stg_valid[fetch_pkg::mem_latency-1] && !rsp_ready;
    assign req_ready = !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stg_valid <= '0;
        end else if (!stall) begin
            stg_valid[0] <= req_valid;
            for (int i = 1; i < fetch_pkg::mem_latency; i++) begin
                stg_valid[i] <= stg_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            mem[fill.addr] <= fill.data;
        end
        if (!stall) begin
            // Same-cycle fill is not visible to this read
            stg_rsp[0].data <= mem[req.addr[fetch_pkg::mem_addr_bits-1:0]];
            stg_rsp[0].tag  <= req.tag;
            for (int i = 1; i < fetch_pkg::mem_latency; i++) begin
                stg_rsp[i] <= stg_rsp[i-1];
            end
        end
    end

    assign rsp_valid = stg_valid[fetch_pkg::mem_latency-1];
    assign rsp       = stg_rsp[fetch_pkg::mem_latency-1];

endmodule

//--- design/fetch_top.sv
module fetch_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            req_valid,
    input  fetch_pkg::ifetch_req_t          req,
    output logic                            req_ready,
    output logic                            rsp_valid,
    output fetch_pkg::ifetch_rsp_t          rsp,
    input  logic                            rsp_ready,
    input  logic [fetch_pkg::num_warps-1:0] ibuf_pop,
    input  logic                            fill_valid,
    input  fetch_pkg::mem_fill_t            fill
);

    logic                   creq_valid;
    logic                   creq_ready;
    fetch_pkg::icache_req_t creq;
    logic                   crsp_valid;
    logic                   crsp_ready;
    fetch_pkg::icache_rsp_t crsp;

    icache_stage u_icache_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .creq_valid (creq_valid),
        .creq       (creq),
        .creq_ready (creq_ready),
        .crsp_valid (crsp_valid),
        .crsp       (crsp),
        .crsp_ready (crsp_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_ready  (rsp_ready),
        .ibuf_pop   (ibuf_pop)
    );

    // Stands in for the instruction cache
    instr_mem u_instr_mem (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (creq_valid),
        .req        (creq),
        .req_ready  (creq_ready),
        .rsp_valid  (crsp_valid),
        .rsp        (crsp),
        .rsp_ready  (crsp_ready),
        .fill_valid (fill_valid),
        .fill       (fill)
    );

endmodule

//--- verif/fetch_checker.sv
module fetch_checker (
    input logic                            clk,
    input logic                            arst_n,
    input logic                            req_valid,
    input fetch_pkg::ifetch_req_t          req,
    input logic                            req_ready,
    input logic                            rsp_valid,
    input fetch_pkg::ifetch_rsp_t          rsp,
    input logic                            rsp_ready,
    input logic [fetch_pkg::num_warps-1:0] ibuf_pop,
    input logic                            fill_valid,
    input fetch_pkg::mem_fill_t            fill
);
    timeunit 1ns;
    timeprecision 1ps;

    // Program image as seen on the fill port
    logic [31:0] mem_model [fetch_pkg::mem_words];

    // Open fetch per warp and its fetched minus popped count
    fetch_pkg::ifetch_req_t          open_req [fetch_pkg::num_warps];
    logic [fetch_pkg::num_warps-1:0] open_valid;
    logic [fetch_pkg::num_warps-1:0] warp_acc;
    int                              ibuf_count [fetch_pkg::num_warps];
    logic                            seen_req;
    logic                            failed = 1'b0;

    always_comb begin
        warp_acc          = '0;
        warp_acc[req.wid] = req_valid && req_ready;
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            mem_model[fill.addr] <= fill.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            open_valid <= '0;
            seen_req   <= 1'b0;
            for (int w = 0; w < fetch_pkg::num_warps; w++) begin
                ibuf_count[w] <= 0;
            end
        end else begin
            if (rsp_valid && rsp_ready) begin
                open_valid[rsp.wid] <= 1'b0;
            end
            if (req_valid && req_ready) begin
                open_valid[req.wid] <= 1'b1;
                open_req[req.wid]   <= req;
                seen_req            <= 1'b1;
            end
            for (int w = 0; w < fetch_pkg::num_warps; w++) begin
                ibuf_count[w] <= ibuf_count[w] + int'(warp_acc[w]) - int'(ibuf_pop[w]);
            end
        end
    end

    // Response belongs to the warp's open fetch and carries the model word
    a_rsp_match: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> open_valid[rsp.wid]
            && rsp.pc == open_req[rsp.wid].pc
            && rsp.tmask == open_req[rsp.wid].tmask
            && rsp.uuid == open_req[rsp.wid].uuid
            && rsp.data == mem_model[open_req[rsp.wid].pc[fetch_pkg::mem_addr_bits+1:2]])
    else begin
        failed = 1'b1;
        $error("Error at %0t: response for warp %0d does not match its fetch", $time, rsp.wid);
    end

    a_ibuf_block: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && ibuf_count[req.wid] == fetch_pkg::ibuf_size + 1 |-> !req_ready)
    else begin
        failed = 1'b1;
        $error("Error at %0t: request accepted for full warp %0d", $time, req.wid);
    end

    // A high rsp_ready last cycle leaves the skid buffer spare empty
    a_ibuf_pass: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && ibuf_count[req.wid] <= fetch_pkg::ibuf_size && $past(rsp_ready)
            |-> req_ready)
    else begin
        failed = 1'b1;
        $error("Error at %0t: request refused for warp %0d with room", $time, req.wid);
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
        failed = 1'b1;
        $error("Error at %0t: held response changed", $time);
    end

    a_no_early_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        !seen_req |-> !rsp_valid)
    else begin
        failed = 1'b1;
        $error("Error at %0t: response before any accepted request", $time);
    end

    a_pc_floor: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> req.pc >= fetch_pkg::startup_addr)
    else begin
        failed = 1'b1;
        $error("Error at %0t: request pc %h below startup address", $time, req.pc);
    end

endmodule

bind fetch_top fetch_checker u_fetch_checker (.*);

//--- verif/fetch_tb.sv
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [fetch_pkg::wid_bits-1:0]      wid_t;
    typedef logic [fetch_pkg::num_threads-1:0]   tmask_t;
    typedef logic [fetch_pkg::mem_addr_bits-1:0] mem_addr_t;

    logic                            clk;
    logic                            arst_n;
    logic                            req_valid;
    fetch_pkg::ifetch_req_t          req;
    logic                            req_ready;
    logic                            rsp_valid;
    fetch_pkg::ifetch_rsp_t          rsp;
    logic                            rsp_ready;
    logic [fetch_pkg::num_warps-1:0] ibuf_pop;
    logic                            fill_valid;
    fetch_pkg::mem_fill_t            fill;

    int fetch_count = 300;
    int cycle_count = 0;
    int accepted;
    // Delivered but not yet popped, per warp
    int held [fetch_pkg::num_warps];
    logic [fetch_pkg::num_warps-1:0] busy;
    logic [fetch_pkg::uuid_bits-1:0] next_uuid;

    fetch_top u_fetch_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : timeout_watch
        int cycle_limit;
        // Reset, program load, worst case per fetch, margin
        cycle_limit = 16 + fetch_pkg::mem_words + fetch_count * 12 + 128;
        wait (cycle_count >= cycle_limit);
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped by the cycle limit");
    end

    initial begin : failure_watch
        wait (u_fetch_top.u_fetch_checker.failed);
        @(negedge clk);
        $display("Simulation finished: FAIL");
        $fatal(1, "A checker assertion failed");
    end

    task automatic load_program();
        for (int i = 0; i < fetch_pkg::mem_words; i++) begin
            @(posedge clk);
            #1;
            fill_valid = 1'b1;
            fill.addr  = mem_addr_t'(i);
            fill.data  = $urandom;
        end
        @(posedge clk);
        #1;
        fill_valid = 1'b0;
    endtask

    // Handshakes that complete on the coming edge
    task automatic track_handshakes();
        if (req_valid && req_ready) begin
            busy[req.wid] = 1'b1;
            accepted++;
        end
        if (rsp_valid && rsp_ready) begin
            busy[rsp.wid] = 1'b0;
            held[rsp.wid]++;
        end
        for (int w = 0; w < fetch_pkg::num_warps; w++) begin
            if (ibuf_pop[w]) begin
                held[w]--;
            end
        end
    endtask

    task automatic drive_cycle(input int step);
        wid_t w;
        logic pop_on;
        // Pops held back for the first 40 of every 128 cycles
        pop_on    = (step % 128) >= 40;
        rsp_ready = ($urandom_range(0, 3) != 0);
        req_valid = 1'b0;
        w = wid_t'($urandom_range(0, fetch_pkg::num_warps - 1));
        if (accepted < fetch_count && !busy[w] && $urandom_range(0, 3) != 0) begin
            req_valid = 1'b1;
            req.wid   = w;
            req.pc    = fetch_pkg::startup_addr + ($urandom & 32'h0000_0ffc);
            req.tmask = tmask_t'($urandom);
            req.uuid  = next_uuid;
            next_uuid++;
        end
        for (int i = 0; i < fetch_pkg::num_warps; i++) begin
            ibuf_pop[i] = pop_on && held[i] > 0 && $urandom_range(0, 1) == 1;
        end
    endtask

    initial begin : stimulus
        int unsigned seed_draw;
        int step;
        seed_draw  = $urandom(84537);
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b1;
        ibuf_pop   = '0;
        fill_valid = 1'b0;
        fill       = '0;
        busy       = '0;
        accepted   = 0;
        next_uuid  = '0;
        for (int w = 0; w < fetch_pkg::num_warps; w++) begin
            held[w] = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        load_program();
        step = 0;
        // Until the fetch count is reached and every fetch is answered
        while (accepted < fetch_count || busy != '0) begin
            @(negedge clk);
            track_handshakes();
            @(posedge clk);
            #1;
            drive_cycle(step);
            step++;
        end
        req_valid = 1'b0;
        ibuf_pop  = '0;
        rsp_ready = 1'b1;
        repeat (4) @(posedge clk);
        // Past the edge, so its assertion results are in
        #1;
        if (u_fetch_top.u_fetch_checker.failed) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "A checker assertion failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- project.f
design/fetch_pkg.sv
design/fetch_meta_ram.sv
design/pending_counter.sv
design/skid_buffer.sv
design/icache_stage.sv
design/instr_mem.sv
design/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fetch stage testbench
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module fetch_tb -f project.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$log_file"; then
    exit 0
fi
echo "Pass message not found in $log_file"
exit 1
